// ==== core_axi_defs.svh ====
`ifndef CORE_AXI_DEFS_SVH
`define CORE_AXI_DEFS_SVH

// bus widths
`define CA_ADDR_W 32
`define CA_DATA_W 32
`define CA_STRB_W 4
`define CA_ID_W 4

// axi channel field widths
`define CA_LEN_W 8
`define CA_SIZE_W 3
`define CA_BURST_W 2
`define CA_RESP_W 2

// axi encodings
`define CA_SIZE_WORD 3'b010
`define CA_BURST_INCR 2'b01
`define CA_RESP_OKAY 2'b00

// one id per client port
`define CA_ID_INST 4'h0
`define CA_ID_DATA 4'h1

`endif

// ==== core_axi_pkg.sv ====
`include "core_axi_defs.svh"

package core_axi_pkg;

    typedef logic [`CA_ADDR_W-1:0] addr_t;
    typedef logic [`CA_DATA_W-1:0] data_t;
    typedef logic [`CA_STRB_W-1:0] strb_t;
    typedef logic [`CA_ID_W-1:0] axi_id_t;
    typedef logic [`CA_RESP_W-1:0] axi_resp_t;

    // client side
    typedef struct packed {
        addr_t addr;
        data_t wdata;
        strb_t wstrb;
        logic  we;
    } mem_req_t;

    typedef struct packed {
        data_t rdata;
        logic  err;
    } mem_rsp_t;

    // arbiter to engine, tagged with the port id
    typedef struct packed {
        axi_id_t  id;
        mem_req_t req;
    } bus_req_t;

    typedef struct packed {
        axi_id_t  id;
        mem_rsp_t rsp;
    } bus_rsp_t;

    // shared by ar and aw
    typedef struct packed {
        axi_id_t               id;
        addr_t                 addr;
        logic [`CA_LEN_W-1:0]   len;
        logic [`CA_SIZE_W-1:0]  size;
        logic [`CA_BURST_W-1:0] burst;
    } axi_addr_t;

    typedef struct packed {
        data_t data;
        strb_t strb;
        logic  last;
    } axi_w_t;

    typedef struct packed {
        axi_id_t   id;
        data_t     data;
        axi_resp_t resp;
        logic      last;
    } axi_r_t;

    typedef struct packed {
        axi_id_t   id;
        axi_resp_t resp;
    } axi_b_t;

    typedef enum logic [2:0] {IDLE, AR, R, AW_W, B} axi_state_e;

endpackage

// ==== mem_port_bridge.sv ====
module mem_port_bridge #(
    parameter bit WRITABLE = 1'b1
) (
    input  logic                   aclk,
    input  logic                   i_rst_n,
    input  logic                   i_req,
    input  core_axi_pkg::mem_req_t i_req_info,
    input  logic                   i_pend_ready,
    input  logic                   i_rsp_valid,
    input  core_axi_pkg::mem_rsp_t i_rsp,
    output logic                   o_ack,
    output core_axi_pkg::mem_rsp_t o_rsp,
    output logic                   o_pend_valid,
    output core_axi_pkg::mem_req_t o_pend
);

    typedef enum logic [1:0] {BR_IDLE, BR_PEND, BR_WAIT, BR_ACK} br_state_e;

    br_state_e              state_q;
    core_axi_pkg::mem_req_t req_masked;
    logic                   capture_req;
    logic                   capture_rsp;

    // fetch port never writes
    always_comb begin
        req_masked    = i_req_info;
        req_masked.we = WRITABLE && i_req_info.we;
    end

    assign capture_req = (state_q == BR_IDLE) && i_req;
    assign capture_rsp = (state_q == BR_WAIT) && i_rsp_valid;

    always_ff @(posedge aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q <= BR_IDLE;
        end else begin
            case (state_q)
                BR_IDLE: begin
                    if (i_req) begin
                        state_q <= BR_PEND;
                    end
                end
                BR_PEND: begin
                    if (i_pend_ready) begin
                        state_q <= BR_WAIT;
                    end
                end
                BR_WAIT: begin
                    if (i_rsp_valid) begin
                        state_q <= BR_ACK;
                    end
                end
                // hold ack until the client lets go
                BR_ACK: begin
                    if (!i_req) begin
                        state_q <= BR_IDLE;
                    end
                end
                default: begin
                    state_q <= BR_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (capture_req) begin
            o_pend <= req_masked;
        end
        if (capture_rsp) begin
            o_rsp <= i_rsp;
        end
    end

    assign o_pend_valid = (state_q == BR_PEND);
    assign o_ack        = (state_q == BR_ACK);

endmodule

// ==== bus_arbiter.sv ====
`include "core_axi_defs.svh"

module bus_arbiter (
    input  logic                         aclk,
    input  logic                         i_rst_n,
    input  logic [1:0]                   i_pend_valid,
    input  core_axi_pkg::mem_req_t [1:0] i_pend,
    input  logic                         i_bus_ready,
    input  logic                         i_rsp_valid,
    input  core_axi_pkg::bus_rsp_t       i_rsp,
    output logic [1:0]                   o_pend_ready,
    output logic                         o_bus_valid,
    output core_axi_pkg::bus_req_t       o_bus,
    output logic [1:0]                   o_rsp_valid,
    output core_axi_pkg::mem_rsp_t       o_rsp
);

    logic busy_q;
    logic last_grant_q;
    logic grant_en;
    logic grant_idx;

    // one transaction in flight at a time
    assign grant_en = !busy_q && (|i_pend_valid);

    // on a tie, serve the port that lost last time
    assign grant_idx = (&i_pend_valid) ? !last_grant_q : i_pend_valid[1];

    always_ff @(posedge aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            busy_q       <= 1'b0;
            last_grant_q <= 1'b1;
            o_pend_ready <= 2'b00;
            o_bus_valid  <= 1'b0;
        end else begin
            o_pend_ready <= 2'b00;
            if (o_bus_valid && i_bus_ready) begin
                o_bus_valid <= 1'b0;
            end
            if (i_rsp_valid) begin
                busy_q <= 1'b0;
            end
            if (grant_en) begin
                busy_q                  <= 1'b1;
                last_grant_q            <= grant_idx;
                o_pend_ready[grant_idx] <= 1'b1;
                o_bus_valid             <= 1'b1;
            end
        end
    end

    always_ff @(posedge aclk) begin
        if (grant_en) begin
            o_bus.id  <= grant_idx ? `CA_ID_DATA : `CA_ID_INST;
            o_bus.req <= i_pend[grant_idx];
        end
    end

    // response goes back by id
    assign o_rsp_valid[0] = i_rsp_valid && (i_rsp.id == `CA_ID_INST);
    assign o_rsp_valid[1] = i_rsp_valid && (i_rsp.id == `CA_ID_DATA);
    assign o_rsp          = i_rsp.rsp;

endmodule

// ==== axi_master_fsm.sv ====
`include "core_axi_defs.svh"

module axi_master_fsm (
    input  logic                    aclk,
    input  logic                    i_rst_n,
    input  logic                    i_bus_valid,
    input  core_axi_pkg::bus_req_t  i_bus,
    input  logic                    i_ar_ready,
    input  logic                    i_aw_ready,
    input  logic                    i_w_ready,
    input  logic                    i_r_valid,
    input  core_axi_pkg::axi_r_t    i_r,
    input  logic                    i_b_valid,
    input  core_axi_pkg::axi_b_t    i_b,
    output logic                    o_bus_ready,
    output logic                    o_rsp_valid,
    output core_axi_pkg::bus_rsp_t  o_rsp,
    output logic                    o_ar_valid,
    output core_axi_pkg::axi_addr_t o_ar,
    output logic                    o_aw_valid,
    output core_axi_pkg::axi_addr_t o_aw,
    output logic                    o_w_valid,
    output core_axi_pkg::axi_w_t    o_w,
    output logic                    o_r_ready,
    output logic                    o_b_ready
);

    core_axi_pkg::axi_state_e state_q;
    core_axi_pkg::bus_req_t   req_q;
    core_axi_pkg::axi_addr_t  addr_beat;
    logic                     aw_done_q;
    logic                     w_done_q;
    logic                     aw_ok;
    logic                     w_ok;

    // aw and w may finish in either order
    assign aw_ok = aw_done_q || (o_aw_valid && i_aw_ready);
    assign w_ok  = w_done_q || (o_w_valid && i_w_ready);

    always_ff @(posedge aclk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state_q     <= core_axi_pkg::IDLE;
            aw_done_q   <= 1'b0;
            w_done_q    <= 1'b0;
            o_rsp_valid <= 1'b0;
        end else begin
            o_rsp_valid <= 1'b0;
            case (state_q)
                core_axi_pkg::IDLE: begin
                    if (i_bus_valid) begin
                        state_q <= i_bus.req.we ? core_axi_pkg::AW_W : core_axi_pkg::AR;
                    end
                end
                core_axi_pkg::AR: begin
                    if (i_ar_ready) begin
                        state_q <= core_axi_pkg::R;
                    end
                end
                core_axi_pkg::R: begin
                    if (i_r_valid) begin
                        state_q     <= core_axi_pkg::IDLE;
                        o_rsp_valid <= 1'b1;
                    end
                end
                core_axi_pkg::AW_W: begin
                    aw_done_q <= aw_ok;
                    w_done_q  <= w_ok;
                    if (aw_ok && w_ok) begin
                        state_q   <= core_axi_pkg::B;
                        aw_done_q <= 1'b0;
                        w_done_q  <= 1'b0;
                    end
                end
                core_axi_pkg::B: begin
                    if (i_b_valid) begin
                        state_q     <= core_axi_pkg::IDLE;
                        o_rsp_valid <= 1'b1;
                    end
                end
                default: begin
                    state_q <= core_axi_pkg::IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge aclk) begin
        if (o_bus_ready) begin
            req_q <= i_bus;
        end
        if ((state_q == core_axi_pkg::R) && i_r_valid) begin
            o_rsp.id        <= i_r.id;
            o_rsp.rsp.rdata <= i_r.data;
            o_rsp.rsp.err   <= (i_r.resp != `CA_RESP_OKAY);
        end
        if ((state_q == core_axi_pkg::B) && i_b_valid) begin
            o_rsp.id        <= i_b.id;
            o_rsp.rsp.rdata <= '0;
            o_rsp.rsp.err   <= (i_b.resp != `CA_RESP_OKAY);
        end
    end

    // single beat, word sized
    always_comb begin
        addr_beat.id    = req_q.id;
        addr_beat.addr  = req_q.req.addr;
        addr_beat.len   = '0;
        addr_beat.size  = `CA_SIZE_WORD;
        addr_beat.burst = `CA_BURST_INCR;
    end

    assign o_ar       = addr_beat;
    assign o_aw       = addr_beat;
    assign o_w.data   = req_q.req.wdata;
    assign o_w.strb   = req_q.req.wstrb;
    assign o_w.last   = 1'b1;

    assign o_bus_ready = (state_q == core_axi_pkg::IDLE) && i_bus_valid;
    assign o_ar_valid  = (state_q == core_axi_pkg::AR);
    assign o_aw_valid  = (state_q == core_axi_pkg::AW_W) && !aw_done_q;
    assign o_w_valid   = (state_q == core_axi_pkg::AW_W) && !w_done_q;
    assign o_r_ready   = (state_q == core_axi_pkg::R);
    assign o_b_ready   = (state_q == core_axi_pkg::B);

endmodule

// ==== core_axi_top.sv ====
module core_axi_top (
    input  logic                    aclk,
    input  logic                    i_rst_n,
    input  logic                    i_i_req,
    input  core_axi_pkg::mem_req_t  i_i_req_info,
    output logic                    o_i_ack,
    output core_axi_pkg::mem_rsp_t  o_i_rsp,
    input  logic                    i_d_req,
    input  core_axi_pkg::mem_req_t  i_d_req_info,
    output logic                    o_d_ack,
    output core_axi_pkg::mem_rsp_t  o_d_rsp,
    output logic                    o_ar_valid,
    output core_axi_pkg::axi_addr_t o_ar,
    input  logic                    i_ar_ready,
    input  logic                    i_r_valid,
    input  core_axi_pkg::axi_r_t    i_r,
    output logic                    o_r_ready,
    output logic                    o_aw_valid,
    output core_axi_pkg::axi_addr_t o_aw,
    input  logic                    i_aw_ready,
    output logic                    o_w_valid,
    output core_axi_pkg::axi_w_t    o_w,
    input  logic                    i_w_ready,
    input  logic                    i_b_valid,
    input  core_axi_pkg::axi_b_t    i_b,
    output logic                    o_b_ready
);

    // index 0 is fetch, index 1 is data
    logic [1:0]                   pend_valid;
    core_axi_pkg::mem_req_t [1:0] pend;
    logic [1:0]                   pend_ready;
    logic [1:0]                   port_rsp_valid;
    core_axi_pkg::mem_rsp_t       port_rsp;
    logic                         bus_valid;
    core_axi_pkg::bus_req_t       bus;
    logic                         bus_ready;
    logic                         eng_rsp_valid;
    core_axi_pkg::bus_rsp_t       eng_rsp;

    mem_port_bridge #(.WRITABLE(1'b0)) u_inst_bridge (
        .aclk(aclk), .i_rst_n(i_rst_n), .i_req(i_i_req), .i_req_info(i_i_req_info),
        .i_pend_ready(pend_ready[0]), .i_rsp_valid(port_rsp_valid[0]), .i_rsp(port_rsp),
        .o_ack(o_i_ack), .o_rsp(o_i_rsp), .o_pend_valid(pend_valid[0]), .o_pend(pend[0])
    );

    mem_port_bridge #(.WRITABLE(1'b1)) u_data_bridge (
        .aclk(aclk), .i_rst_n(i_rst_n), .i_req(i_d_req), .i_req_info(i_d_req_info),
        .i_pend_ready(pend_ready[1]), .i_rsp_valid(port_rsp_valid[1]), .i_rsp(port_rsp),
        .o_ack(o_d_ack), .o_rsp(o_d_rsp), .o_pend_valid(pend_valid[1]), .o_pend(pend[1])
    );

    bus_arbiter u_arbiter (
        .aclk(aclk), .i_rst_n(i_rst_n), .i_pend_valid(pend_valid), .i_pend(pend),
        .i_bus_ready(bus_ready), .i_rsp_valid(eng_rsp_valid), .i_rsp(eng_rsp),
        .o_pend_ready(pend_ready), .o_bus_valid(bus_valid), .o_bus(bus),
        .o_rsp_valid(port_rsp_valid), .o_rsp(port_rsp)
    );

    axi_master_fsm u_axi_master (
        .aclk(aclk), .i_rst_n(i_rst_n), .i_bus_valid(bus_valid), .i_bus(bus),
        .i_ar_ready(i_ar_ready), .i_aw_ready(i_aw_ready), .i_w_ready(i_w_ready),
        .i_r_valid(i_r_valid), .i_r(i_r), .i_b_valid(i_b_valid), .i_b(i_b),
        .o_bus_ready(bus_ready), .o_rsp_valid(eng_rsp_valid), .o_rsp(eng_rsp),
        .o_ar_valid(o_ar_valid), .o_ar(o_ar), .o_aw_valid(o_aw_valid), .o_aw(o_aw),
        .o_w_valid(o_w_valid), .o_w(o_w), .o_r_ready(o_r_ready), .o_b_ready(o_b_ready)
    );

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen (
    output logic o_clk
);

    // period of 4
    initial begin
        o_clk = 1'b0;
    end

    always begin
        #2 o_clk = ~o_clk;
    end

endmodule

// ==== tb_axi_mem.sv ====
`include "core_axi_defs.svh"

module tb_axi_mem (
    input  logic                    aclk,
    input  logic                    i_rst_n,
    input  logic                    i_ar_valid,
    input  core_axi_pkg::axi_addr_t i_ar,
    output logic                    o_ar_ready,
    output logic                    o_r_valid,
    output core_axi_pkg::axi_r_t    o_r,
    input  logic                    i_r_ready,
    input  logic                    i_aw_valid,
    input  core_axi_pkg::axi_addr_t i_aw,
    output logic                    o_aw_ready,
    input  logic                    i_w_valid,
    input  core_axi_pkg::axi_w_t    i_w,
    output logic                    o_w_ready,
    output logic                    o_b_valid,
    output core_axi_pkg::axi_b_t    o_b,
    input  logic                    i_b_ready,
    output logic                    o_timeout
);

    localparam int LIMIT = 200;

    core_axi_pkg::data_t mem [256];
    logic [31:0]         lfsr_q;

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    // 0 to 3 cycles
    function automatic int delay_cycles();
        logic [1:0] d;
        d[1] = lfsr_bit();
        d[0] = lfsr_bit();
        return int'(d);
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge aclk);
            #1;
        end
    endtask

    initial begin
        core_axi_pkg::axi_addr_t aw;
        core_axi_pkg::axi_w_t    w;
        core_axi_pkg::axi_addr_t ar;
        int                      n;
        logic                    err;
        o_ar_ready = 1'b0;
        o_r_valid  = 1'b0;
        o_r        = '0;
        o_aw_ready = 1'b0;
        o_w_ready  = 1'b0;
        o_b_valid  = 1'b0;
        o_b        = '0;
        o_timeout  = 1'b0;
        lfsr_q     = 32'h1bff_d64a;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 32'(i) ^ 32'h5a5a_0000;
        end
        @(posedge i_rst_n);
        forever begin
            @(posedge aclk);
            #1;
            if (i_ar_valid) begin
                idle_cycles(delay_cycles());
                ar = i_ar;
                o_ar_ready = 1'b1;
                idle_cycles(1);
                o_ar_ready = 1'b0;
                idle_cycles(delay_cycles());
                err = ar.addr >= 32'hF000_0000;
                o_r.id   = ar.id;
                o_r.data = err ? '0 : mem[ar.addr[9:2]];
                o_r.resp = err ? 2'b10 : `CA_RESP_OKAY;
                o_r.last = 1'b1;
                o_r_valid = 1'b1;
                n = 0;
                while (!i_r_ready && n < LIMIT) begin
                    idle_cycles(1);
                    n++;
                end
                if (n == LIMIT) begin
                    o_timeout = 1'b1;
                end
                idle_cycles(1);
                o_r_valid = 1'b0;
            end else if (i_aw_valid || i_w_valid) begin
                // address and data accepted independently
                fork
                    begin
                        idle_cycles(delay_cycles());
                        aw = i_aw;
                        o_aw_ready = 1'b1;
                        idle_cycles(1);
                        o_aw_ready = 1'b0;
                    end
                    begin
                        idle_cycles(delay_cycles());
                        w = i_w;
                        o_w_ready = 1'b1;
                        idle_cycles(1);
                        o_w_ready = 1'b0;
                    end
                join
                err = aw.addr >= 32'hF000_0000;
                if (!err) begin
                    for (int b = 0; b < 4; b++) begin
                        if (w.strb[b]) begin
                            mem[aw.addr[9:2]][8*b +: 8] = w.data[8*b +: 8];
                        end
                    end
                end
                idle_cycles(delay_cycles());
                o_b.id   = aw.id;
                o_b.resp = err ? 2'b10 : `CA_RESP_OKAY;
                o_b_valid = 1'b1;
                n = 0;
                while (!i_b_ready && n < LIMIT) begin
                    idle_cycles(1);
                    n++;
                end
                if (n == LIMIT) begin
                    o_timeout = 1'b1;
                end
                idle_cycles(1);
                o_b_valid = 1'b0;
            end
        end
    end

endmodule

// ==== tb_core_axi.sv ====
`include "core_axi_defs.svh"

module tb_core_axi;

    localparam int TIMEOUT = 200;
    localparam int TOTAL   = 117;

    typedef struct {
        logic                   port;
        core_axi_pkg::mem_req_t req;
        core_axi_pkg::mem_rsp_t rsp;
    } txn_t;

    logic                    aclk;
    logic                    rst_n;
    logic                    inst_req;
    core_axi_pkg::mem_req_t  inst_info;
    logic                    inst_ack;
    core_axi_pkg::mem_rsp_t  inst_rsp;
    logic                    data_req;
    core_axi_pkg::mem_req_t  data_info;
    logic                    data_ack;
    core_axi_pkg::mem_rsp_t  data_rsp;
    logic                    ar_valid;
    core_axi_pkg::axi_addr_t ar;
    logic                    ar_ready;
    logic                    r_valid;
    core_axi_pkg::axi_r_t    r;
    logic                    r_ready;
    logic                    aw_valid;
    core_axi_pkg::axi_addr_t aw;
    logic                    aw_ready;
    logic                    w_valid;
    core_axi_pkg::axi_w_t    w;
    logic                    w_ready;
    logic                    b_valid;
    core_axi_pkg::axi_b_t    b;
    logic                    b_ready;
    logic                    mem_timeout;

    txn_t                    done_q[$];
    core_axi_pkg::axi_id_t   ar_ids[$];
    core_axi_pkg::data_t     shadow [256];
    core_axi_pkg::mem_req_t  cur_req [2];
    logic [1:0]              active;
    logic [31:0]             lfsr_q;
    int                      checked;

    tb_clk_gen u_clk (.o_clk(aclk));

    core_axi_top dut (
        .aclk(aclk), .i_rst_n(rst_n),
        .i_i_req(inst_req), .i_i_req_info(inst_info), .o_i_ack(inst_ack), .o_i_rsp(inst_rsp),
        .i_d_req(data_req), .i_d_req_info(data_info), .o_d_ack(data_ack), .o_d_rsp(data_rsp),
        .o_ar_valid(ar_valid), .o_ar(ar), .i_ar_ready(ar_ready),
        .i_r_valid(r_valid), .i_r(r), .o_r_ready(r_ready),
        .o_aw_valid(aw_valid), .o_aw(aw), .i_aw_ready(aw_ready),
        .o_w_valid(w_valid), .o_w(w), .i_w_ready(w_ready),
        .i_b_valid(b_valid), .i_b(b), .o_b_ready(b_ready)
    );

    tb_axi_mem u_mem (
        .aclk(aclk), .i_rst_n(rst_n),
        .i_ar_valid(ar_valid), .i_ar(ar), .o_ar_ready(ar_ready),
        .o_r_valid(r_valid), .o_r(r), .i_r_ready(r_ready),
        .i_aw_valid(aw_valid), .i_aw(aw), .o_aw_ready(aw_ready),
        .i_w_valid(w_valid), .i_w(w), .o_w_ready(w_ready),
        .o_b_valid(b_valid), .o_b(b), .i_b_ready(b_ready), .o_timeout(mem_timeout)
    );

    function automatic logic lfsr_bit();
        logic fb;
        fb = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
        lfsr_q = {lfsr_q[30:0], fb};
        return fb;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int k = 0; k < n; k++) begin
            v = {v[30:0], lfsr_bit()};
        end
        return v;
    endfunction

    function automatic core_axi_pkg::mem_req_t make_req(input logic [31:0] addr,
            input logic we, input logic [31:0] wdata, input logic [3:0] wstrb);
        core_axi_pkg::mem_req_t q;
        q.addr  = addr;
        q.we    = we;
        q.wdata = wdata;
        q.wstrb = wstrb;
        return q;
    endfunction

    // fetch port reads even when we is set; error region at 0xF000_0000 and up
    function automatic core_axi_pkg::mem_rsp_t expected_rsp(input logic port,
            input core_axi_pkg::mem_req_t req);
        core_axi_pkg::mem_rsp_t e;
        e.err   = req.addr >= 32'hF000_0000;
        e.rdata = ((port && req.we) || e.err) ? '0 : shadow[req.addr[9:2]];
        return e;
    endfunction

    task automatic update_shadow(input logic port, input core_axi_pkg::mem_req_t req);
        if (port && req.we && req.addr < 32'hF000_0000) begin
            for (int k = 0; k < 4; k++) begin
                if (req.wstrb[k]) begin
                    shadow[req.addr[9:2]][8*k +: 8] = req.wdata[8*k +: 8];
                end
            end
        end
    endtask

    task automatic fail_now(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_rsp(input core_axi_pkg::mem_rsp_t got,
            input core_axi_pkg::mem_rsp_t exp, input string name);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_addr(input core_axi_pkg::axi_addr_t got,
            input core_axi_pkg::axi_addr_t exp, input string name);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_wbeat(input core_axi_pkg::axi_w_t got,
            input core_axi_pkg::axi_w_t exp, input string name);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    task automatic check_id(input core_axi_pkg::axi_id_t got,
            input core_axi_pkg::axi_id_t exp, input string name);
        if (got !== exp) begin
            fail_now($sformatf("Mismatch %s: got %h expected %h", name, got, exp));
        end
    endtask

    // one full four-phase handshake on one client port
    task automatic run_txn(input logic port, input core_axi_pkg::mem_req_t req);
        int   n;
        txn_t t;
        @(posedge aclk);
        #1;
        cur_req[port] = req;
        active[port]  = 1'b1;
        if (port) begin
            data_info = req;
            data_req  = 1'b1;
        end else begin
            inst_info = req;
            inst_req  = 1'b1;
        end
        n = 0;
        while (!(port ? data_ack : inst_ack) && n < TIMEOUT) begin
            @(posedge aclk);
            #1;
            n++;
        end
        if (n == TIMEOUT) begin
            fail_now($sformatf("port %0d never raised ack", port));
        end
        t.port = port;
        t.req  = req;
        t.rsp  = port ? data_rsp : inst_rsp;
        done_q.push_back(t);
        active[port] = 1'b0;
        if (port) begin
            data_req = 1'b0;
        end else begin
            inst_req = 1'b0;
        end
        n = 0;
        while ((port ? data_ack : inst_ack) && n < TIMEOUT) begin
            @(posedge aclk);
            #1;
            n++;
        end
        if (n == TIMEOUT) begin
            fail_now($sformatf("port %0d kept ack high after req fell", port));
        end
    endtask

    always @(negedge aclk) begin
        txn_t                   t;
        core_axi_pkg::mem_rsp_t e;
        while (done_q.size() > 0) begin
            t = done_q.pop_front();
            e = expected_rsp(t.port, t.req);
            check_rsp(t.rsp, e, t.port ? "o_d_rsp" : "o_i_rsp");
            update_shadow(t.port, t.req);
            checked++;
        end
    end

    // bus beat monitor
    always @(negedge aclk) begin
        core_axi_pkg::axi_addr_t e;
        core_axi_pkg::axi_w_t    ew;
        if (rst_n && ar_valid && ar_ready) begin
            e.id = (active[0] && cur_req[0].addr == ar.addr) ? `CA_ID_INST : `CA_ID_DATA;
            e.addr  = cur_req[e.id[0]].addr;
            e.len   = '0;
            e.size  = `CA_SIZE_WORD;
            e.burst = `CA_BURST_INCR;
            check_id(ar.id, e.id, "o_ar.id");
            check_addr(ar, e, "o_ar");
            ar_ids.push_back(ar.id);
        end
        if (rst_n && aw_valid && aw_ready) begin
            e.id    = `CA_ID_DATA;
            e.addr  = cur_req[1].addr;
            e.len   = '0;
            e.size  = `CA_SIZE_WORD;
            e.burst = `CA_BURST_INCR;
            check_addr(aw, e, "o_aw");
        end
        if (rst_n && w_valid && w_ready) begin
            ew.data = cur_req[1].wdata;
            ew.strb = cur_req[1].wstrb;
            ew.last = 1'b1;
            check_wbeat(w, ew, "o_w");
        end
    end

    always @(posedge aclk) begin
        if (mem_timeout) begin
            fail_now("memory model timed out waiting for a ready from the DUT");
        end
    end

    initial begin
        logic [31:0] v;
        inst_req  = 1'b0;
        inst_info = '0;
        data_req  = 1'b0;
        data_info = '0;
        rst_n     = 1'b0;
        active    = 2'b00;
        checked   = 0;
        lfsr_q    = 32'h1bff_d64a;
        cur_req[0] = '0;
        cur_req[1] = '0;
        for (int i = 0; i < 256; i++) begin
            shadow[i] = 32'(i) ^ 32'h5a5a_0000;
        end
        repeat (2) @(posedge aclk);
        #1;
        rst_n = 1'b1;

        run_txn(1'b0, make_req(32'h10, 1'b0, '0, 4'h0));
        // partial write then read back
        run_txn(1'b1, make_req(32'h44, 1'b1, 32'hdead_beef, 4'b0101));
        run_txn(1'b1, make_req(32'h44, 1'b0, '0, 4'h0));
        // fetch with we set must not write
        run_txn(1'b0, make_req(32'h48, 1'b1, 32'h1234_5678, 4'hf));
        run_txn(1'b1, make_req(32'h48, 1'b0, '0, 4'h0));

        ar_ids.delete();
        fork
            for (int k = 0; k < 4; k++) begin
                run_txn(1'b0, make_req(32'h100 + 32'(4 * k), 1'b0, '0, 4'h0));
            end
            for (int k = 0; k < 4; k++) begin
                run_txn(1'b1, make_req(32'h200 + 32'(4 * k), 1'b0, '0, 4'h0));
            end
        join
        if (ar_ids.size() != 8) begin
            fail_now("contention phase did not see eight read addresses");
        end
        // data port was served last, so fetch wins the first tie
        for (int k = 0; k < 8; k++) begin
            check_id(ar_ids[k], (k % 2 == 1) ? `CA_ID_DATA : `CA_ID_INST, "ar id order");
        end

        run_txn(1'b1, make_req(32'hF000_0010, 1'b1, 32'hffff_ffff, 4'hf));
        run_txn(1'b1, make_req(32'hF000_0010, 1'b0, '0, 4'h0));
        run_txn(1'b0, make_req(32'hF000_0010, 1'b0, '0, 4'h0));
        run_txn(1'b1, make_req(32'h10, 1'b0, '0, 4'h0));

        // fetch in the low half, data in the high half, so no overlap
        fork
            for (int k = 0; k < 50; k++) begin
                v = rand_bits(10);
                run_txn(1'b0, make_req((v[9:7] == 3'd0 ? 32'hF000_0000 : 32'h0)
                    | {23'd0, v[6:0], 2'b00}, v[8], '0, 4'h0));
            end
            for (int k = 0; k < 50; k++) begin
                v = rand_bits(11);
                run_txn(1'b1, make_req((v[10:8] == 3'd0 ? 32'hF800_0000 : 32'h200)
                    | {23'd0, v[6:0], 2'b00}, v[7], rand_bits(32), 4'(rand_bits(4))));
            end
        join

        repeat (2) @(posedge aclk);
        if (done_q.size() == 0 && checked == TOTAL) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            fail_now($sformatf("only %0d of %0d transactions were checked", checked, TOTAL));
        end
    end

endmodule

// ==== sources.f ====
+incdir+.
core_axi_pkg.sv
mem_port_bridge.sv
bus_arbiter.sv
axi_master_fsm.sv
core_axi_top.sv
tb_clk_gen.sv
tb_axi_mem.sv
tb_core_axi.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_core_axi
FILELIST  ?= sources.f
BUILD_DIR ?= obj_dir
SIM_BIN   ?= sim_$(TOP)
VFLAGS    ?= --timing
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/$(SIM_BIN): $(FILELIST) $(shell cat $(FILELIST) | grep -v '^+')
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o $(SIM_BIN)

sim: $(BUILD_DIR)/$(SIM_BIN)
	@./$(BUILD_DIR)/$(SIM_BIN) | awk '{ print } $$0 == "$(PASS_MSG)" { ok = 1 } \
		END { exit !ok }'

clean:
	rm -rf $(BUILD_DIR)
